// ==== vlog.f ====
+incdir+verification
src/llc_pkg.sv
src/llc_localmem.sv
src/llc_lookup_way.sv
src/llc_process_request.sv
src/llc_core.sv
verification/tb_llc.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP      = tb_llc
FILELIST = vlog.f
BUILD    = obj_dir
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== verification/llc_ref_model.svh ====
////////////////////////////////////////////////////////////////////////////
// cache reference model
////////////////////////////////////////////////////////////////////////////

`ifndef LLC_REF_MODEL_SVH
`define LLC_REF_MODEL_SVH

// same geometry as the DUT defaults
localparam int SET_BITS = 4;
localparam int WAY_BITS = 2;
localparam int SETS     = 1 << SET_BITS;
localparam int WAYS     = 1 << WAY_BITS;

line_addr_t m_addr   [SETS][WAYS];
llc_state_e m_state  [SETS][WAYS];
line_t      m_line   [SETS][WAYS];
int         m_ptr    [SETS];
line_t      m_memory [line_addr_t];

task automatic clear_model();
    for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < WAYS; w++) begin
            m_state[s][w] = INVALID;
            m_addr[s][w]  = '0;
            m_line[s][w]  = '0;
        end
        m_ptr[s] = 0;
    end
endtask

// untouched lines read a pattern built from the whole line address
function automatic line_t memory_line(input line_addr_t addr);
    line_t l;
    if (m_memory.exists(addr)) begin
        return m_memory[addr];
    end
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
        l[w] = {addr, 4'(w)} ^ 32'h5a5a_0f0f;
    end
    return l;
endfunction

task automatic predict_access(input llc_req_t r, output logic hit, output line_t rsp_line,
                              output logic wb, output mem_req_t wb_req, output logic fill);
    int s;
    int v;
    s      = int'(r.addr[SET_BITS-1:0]);
    hit    = 1'b0;
    wb     = 1'b0;
    fill   = 1'b0;
    wb_req = '0;
    v      = 0;
    for (int w = WAYS - 1; w >= 0; w--) begin
        if (m_state[s][w] != INVALID && m_addr[s][w] == r.addr) begin
            hit = 1'b1;
            v   = w;
        end
    end
    if (hit) begin
        if (r.op == OP_WRITE) begin
            m_line[s][v]  = r.line;
            m_state[s][v] = DIRTY;
        end
    end else begin
        // lowest invalid way, else round robin
        v = m_ptr[s];
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (m_state[s][w] == INVALID) begin
                v = w;
            end
        end
        wb = (m_state[s][v] == DIRTY);
        wb_req.write = 1'b1;
        wb_req.addr  = m_addr[s][v];
        wb_req.line  = m_line[s][v];
        if (wb) begin
            m_memory[m_addr[s][v]] = m_line[s][v];
        end
        fill          = (r.op == OP_READ);
        m_line[s][v]  = fill ? memory_line(r.addr) : r.line;
        m_state[s][v] = fill ? VALID : DIRTY;
        m_addr[s][v]  = r.addr;
        m_ptr[s]      = (m_ptr[s] + 1) % WAYS;
    end
    rsp_line = m_line[s][v];
endtask

`endif

// ==== verification/tb_llc.sv ====
////////////////////////////////////////////////////////////////////////////
// last-level cache testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_llc;
    import llc_pkg::*;

    `include "llc_ref_model.svh"

    localparam int TIMEOUT = 1000;

    logic       clk;
    logic       rst;
    logic       req_valid;
    llc_req_t   req;
    logic       req_ready;
    logic       rsp_valid;
    llc_rsp_t   rsp;
    logic       rsp_ready;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       mem_req_ready;
    logic       mem_rsp_valid;
    mem_rsp_t   mem_rsp;
    logic       mem_rsp_ready;

    integer     seed = 68066;
    int         errors = 0;
    bit         timed_out = 1'b0;
    bit         stall_en = 1'b0;
    int         fill_delay;
    mem_req_t   wb_expected[$];
    line_addr_t fill_expected[$];

    logic       mem_hold = 1'b0;
    logic       rsp_hold = 1'b0;
    mem_req_t   mem_req_last;
    llc_rsp_t   rsp_last;

    llc_core u_llc_core (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .req_ready_o     (req_ready),
        .rsp_valid_o     (rsp_valid),
        .rsp_o           (rsp),
        .rsp_ready_i     (rsp_ready),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_o       (mem_req),
        .mem_req_ready_i (mem_req_ready),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_i       (mem_rsp),
        .mem_rsp_ready_o (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_equal(input logic [159:0] got, input logic [159:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // one request from issue to response, checked against the model
    task automatic send_request(input llc_op_e op, input line_addr_t addr, input line_t data,
                                output int latency);
        llc_req_t r;
        logic     exp_hit;
        line_t    exp_line;
        logic     wb;
        mem_req_t wb_req;
        logic     fill;
        int       waited;
        bit       done;
        latency = -1;
        if (timed_out) begin
            return;
        end
        r.op   = op;
        r.addr = addr;
        r.line = data;
        #1;
        req_valid = 1'b1;
        req       = r;
        waited    = 0;
        done      = 1'b0;
        while (!done && waited <= TIMEOUT) begin
            @(posedge clk);
            done = req_ready;
            waited++;
        end
        if (!done) begin
            note_failure($sformatf("request for line %h was never accepted", addr));
            timed_out = 1'b1;
            return;
        end
        predict_access(r, exp_hit, exp_line, wb, wb_req, fill);
        if (wb) begin
            wb_expected.push_back(wb_req);
        end
        if (fill) begin
            fill_expected.push_back(addr);
        end
        #1;
        req_valid = 1'b0;
        req       = '0;
        // waited counts edges after the accepting one
        waited = 0;
        done   = 1'b0;
        while (!done && waited <= TIMEOUT) begin
            @(posedge clk);
            if (rsp_valid && latency < 0) begin
                latency = waited;
            end
            done = rsp_valid && rsp_ready;
            waited++;
        end
        if (!done) begin
            note_failure($sformatf("no response for line %h", addr));
            timed_out = 1'b1;
            return;
        end
        check_equal(160'(rsp.hit), 160'(exp_hit), $sformatf("hit flag of line %h", addr));
        check_equal(160'(rsp.line), 160'(exp_line), $sformatf("data of line %h", addr));
        if (wb_expected.size() != 0 || fill_expected.size() != 0) begin
            note_failure($sformatf("memory traffic missing for line %h", addr));
            wb_expected.delete();
            fill_expected.delete();
        end
    endtask

    // ready back-pressure and fill delay, all drawn after the edge
    initial begin : ready_driver
        rsp_ready     = 1'b0;
        mem_req_ready = 1'b0;
        fill_delay    = 0;
        forever begin
            @(posedge clk);
            #1;
            if (stall_en) begin
                rsp_ready     = ($random(seed) & 3) != 0;
                mem_req_ready = ($random(seed) & 1) != 0;
            end else begin
                rsp_ready     = 1'b1;
                mem_req_ready = 1'b1;
            end
            fill_delay = $random(seed) & 7;
        end
    end

    initial begin : memory_responder
        mem_req_t   mr;
        mem_req_t   exp_wb;
        line_addr_t exp_fill;
        int         delay;
        int         waited;
        bit         done;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        forever begin
            @(posedge clk);
            if (rst && mem_req_valid && mem_req_ready) begin
                mr = mem_req;
                if (mr.write) begin
                    if (wb_expected.size() == 0) begin
                        note_failure($sformatf("unexpected memory write to line %h", mr.addr));
                    end else begin
                        exp_wb = wb_expected.pop_front();
                        check_equal(160'(mr), 160'(exp_wb), "memory write back");
                    end
                end else begin
                    if (wb_expected.size() != 0) begin
                        note_failure("fill requested before the dirty victim was written");
                    end
                    if (fill_expected.size() == 0) begin
                        note_failure($sformatf("unexpected fill of line %h", mr.addr));
                    end else begin
                        exp_fill = fill_expected.pop_front();
                        check_equal(160'(mr.addr), 160'(exp_fill), "fill line address");
                    end
                    delay = fill_delay;
                    repeat (delay) @(posedge clk);
                    #1;
                    mem_rsp_valid = 1'b1;
                    mem_rsp.line  = memory_line(mr.addr);
                    waited        = 0;
                    done          = 1'b0;
                    while (!done && waited <= TIMEOUT) begin
                        @(posedge clk);
                        done = mem_rsp_ready;
                        waited++;
                    end
                    if (!done) begin
                        note_failure("fill data was never taken by the cache");
                    end
                    #1;
                    mem_rsp_valid = 1'b0;
                    mem_rsp       = '0;
                end
            end
        end
    end

    // valid and payload must hold until the transfer
    always @(posedge clk) begin
        if (mem_hold) begin
            check_equal(160'(mem_req_valid), 160'(1'b1), "memory request valid under stall");
            check_equal(160'(mem_req), 160'(mem_req_last), "memory request under stall");
        end
        if (rsp_hold) begin
            check_equal(160'(rsp_valid), 160'(1'b1), "response valid under stall");
            check_equal(160'(rsp), 160'(rsp_last), "response under stall");
        end
        mem_hold     <= rst && mem_req_valid && !mem_req_ready;
        mem_req_last <= mem_req;
        rsp_hold     <= rst && rsp_valid && !rsp_ready;
        rsp_last     <= rsp;
    end

    initial begin : stimulus
        int         latency;
        llc_op_e    op;
        line_addr_t addr;
        line_t      data;
        int         tag_sel;
        logic [3:0] set_sel;
        rst       = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        clear_model();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        check_equal(160'(req_ready), 160'(1'b1), "req_ready after reset");
        check_equal(160'(rsp_valid), 160'(1'b0), "rsp_valid after reset");
        check_equal(160'(mem_req_valid), 160'(1'b0), "mem_req_valid after reset");
        check_equal(160'(mem_rsp_ready), 160'(1'b0), "mem_rsp_ready after reset");

        // cold miss, then a hit with fixed latency
        send_request(OP_READ, 28'h0000113, '0, latency);
        send_request(OP_READ, 28'h0000113, '0, latency);
        check_equal(160'(latency), 160'(2), "hit response latency");
        send_request(OP_WRITE, 28'h0000123, {32'hcafe_0003, 32'h1234_5678, 32'h0, 32'h7}, latency);
        send_request(OP_READ, 28'h0000123, '0, latency);
        // overflow set 9 with dirty lines
        for (int t = 1; t <= 5; t++) begin
            data = {4{32'(t) ^ 32'hd1d1_0000}};
            send_request(OP_WRITE, {24'(t), 4'h9}, data, latency);
        end
        send_request(OP_READ, {24'(6), 4'h9}, '0, latency);
        send_request(OP_READ, {24'(1), 4'h9}, '0, latency);

        stall_en = 1'b1;
        for (int i = 0; i < 400 && !timed_out; i++) begin
            op      = llc_op_e'($random(seed) & 1);
            tag_sel = $random(seed) & 7;
            set_sel = (($random(seed) & 1) != 0) ? 4'h9 : 4'h3;
            addr    = {24'(tag_sel), set_sel};
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                data[w] = $random(seed);
            end
            send_request(op, addr, data, latency);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== src/llc_core.sv ====
////////////////////////////////////////////////////////////////////////////
// last-level cache core
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_core #(
    parameter int SET_BITS = 4,
    parameter int WAY_BITS = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid_i,
    input  llc_pkg::llc_req_t   req_i,
    output logic                req_ready_o,
    output logic                rsp_valid_o,
    output llc_pkg::llc_rsp_t   rsp_o,
    input  logic                rsp_ready_i,
    output logic                mem_req_valid_o,
    output llc_pkg::mem_req_t   mem_req_o,
    input  logic                mem_req_ready_i,
    input  logic                mem_rsp_valid_i,
    input  llc_pkg::mem_rsp_t   mem_rsp_i,
    output logic                mem_rsp_ready_o
);
    import llc_pkg::*;

    localparam int TAG_BITS = LINE_ADDR_BITS - SET_BITS;
    localparam int WAYS = 1 << WAY_BITS;

    stage_e                        stage_q;
    stage_e                        stage_d;
    llc_req_t                      req_q;
    logic                          accept;
    logic                          start_q;
    logic                          upd_wr_q;
    logic                          fill_q;
    logic                          hit_q;
    logic                          wr_en;
    logic [SET_BITS-1:0]           set;
    logic [TAG_BITS-1:0]           tag;

    logic [WAYS-1:0][TAG_BITS-1:0] rd_tags;
    llc_state_e [WAYS-1:0]         rd_states;
    line_t [WAYS-1:0]              rd_lines;
    logic [WAY_BITS-1:0]           rd_evict_way;

    logic                          lk_hit;
    logic [WAY_BITS-1:0]           lk_hit_way;
    logic [WAY_BITS-1:0]           lk_victim_way;
    logic                          lk_victim_dirty;
    logic [TAG_BITS-1:0]           lk_victim_tag;
    line_t                         lk_victim_line;
    line_t                         lk_hit_line;

    logic                          pr_done;
    logic [WAY_BITS-1:0]           pr_upd_way;
    llc_state_e                    pr_upd_state;
    line_t                         pr_upd_line;
    logic                          pr_fill;
    line_t                         pr_rsp_line;

    logic [WAY_BITS-1:0]           upd_way_q;
    llc_state_e                    upd_state_q;
    line_t                         upd_line_q;
    line_t                         rsp_line_q;

    assign req_ready_o = (stage_q == READ_MEM);
    assign accept      = req_valid_i && req_ready_o;
    assign set         = req_q.addr[SET_BITS-1:0];
    assign tag         = req_q.addr[LINE_ADDR_BITS-1:SET_BITS];

    // read hits leave the arrays untouched
    assign wr_en = upd_wr_q && (req_q.op == OP_WRITE || !hit_q);

    assign rsp_valid_o = (stage_q == UPDATE);
    assign rsp_o.line  = rsp_line_q;
    assign rsp_o.hit   = hit_q;

    always_comb begin
        stage_d = stage_q;
        case (stage_q)
            READ_MEM: begin
                if (accept) begin
                    stage_d = LOOKUP;
                end
            end
            LOOKUP: begin
                stage_d = PROCESS;
            end
            PROCESS: begin
                if (pr_done) begin
                    stage_d = UPDATE;
                end
            end
            UPDATE: begin
                if (rsp_ready_i) begin
                    stage_d = READ_MEM;
                end
            end
            default: begin
                stage_d = READ_MEM;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stage_q  <= READ_MEM;
            start_q  <= 1'b0;
            upd_wr_q <= 1'b0;
            fill_q   <= 1'b0;
        end else begin
            stage_q  <= stage_d;
            // lookup always lasts one cycle, so this marks PROCESS entry
            start_q  <= (stage_q == LOOKUP);
            upd_wr_q <= pr_done;
            if (pr_done) begin
                fill_q <= pr_fill;
            end
        end
    end

    // request and result registers
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (pr_done) begin
            hit_q       <= lk_hit;
            rsp_line_q  <= pr_rsp_line;
            upd_way_q   <= pr_upd_way;
            upd_state_q <= pr_upd_state;
            upd_line_q  <= pr_upd_line;
        end
    end

    llc_localmem #(
        .SET_BITS(SET_BITS),
        .WAY_BITS(WAY_BITS)
    ) u_localmem (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (accept),
        .rd_set_i       (req_i.addr[SET_BITS-1:0]),
        .wr_en_i        (wr_en),
        .wr_set_i       (set),
        .wr_way_i       (upd_way_q),
        .wr_tag_i       (tag),
        .wr_state_i     (upd_state_q),
        .wr_line_i      (upd_line_q),
        .incr_evict_i   (upd_wr_q && fill_q),
        .rd_tags_o      (rd_tags),
        .rd_states_o    (rd_states),
        .rd_lines_o     (rd_lines),
        .rd_evict_way_o (rd_evict_way)
    );

    llc_lookup_way #(
        .SET_BITS(SET_BITS),
        .WAY_BITS(WAY_BITS)
    ) u_lookup_way (
        .tag_i          (tag),
        .tags_i         (rd_tags),
        .states_i       (rd_states),
        .lines_i        (rd_lines),
        .evict_way_i    (rd_evict_way),
        .hit_o          (lk_hit),
        .hit_way_o      (lk_hit_way),
        .victim_way_o   (lk_victim_way),
        .victim_dirty_o (lk_victim_dirty),
        .victim_tag_o   (lk_victim_tag),
        .victim_line_o  (lk_victim_line),
        .hit_line_o     (lk_hit_line)
    );

    llc_process_request #(
        .SET_BITS(SET_BITS),
        .WAY_BITS(WAY_BITS)
    ) u_process_request (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start_q),
        .req_i           (req_q),
        .hit_i           (lk_hit),
        .hit_way_i       (lk_hit_way),
        .hit_line_i      (lk_hit_line),
        .victim_way_i    (lk_victim_way),
        .victim_dirty_i  (lk_victim_dirty),
        .victim_tag_i    (lk_victim_tag),
        .victim_line_i   (lk_victim_line),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .done_o          (pr_done),
        .upd_way_o       (pr_upd_way),
        .upd_state_o     (pr_upd_state),
        .upd_line_o      (pr_upd_line),
        .fill_o          (pr_fill),
        .rsp_line_o      (pr_rsp_line)
    );

endmodule

// ==== src/llc_process_request.sv ====
////////////////////////////////////////////////////////////////////////////
// request processing, hit and miss handling
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_process_request #(
    parameter int SET_BITS = 4,
    parameter int WAY_BITS = 2,
    localparam int TAG_BITS = llc_pkg::LINE_ADDR_BITS - SET_BITS
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  llc_pkg::llc_req_t       req_i,
    input  logic                    hit_i,
    input  logic [WAY_BITS-1:0]     hit_way_i,
    input  llc_pkg::line_t          hit_line_i,
    input  logic [WAY_BITS-1:0]     victim_way_i,
    input  logic                    victim_dirty_i,
    input  logic [TAG_BITS-1:0]     victim_tag_i,
    input  llc_pkg::line_t          victim_line_i,
    input  logic                    mem_req_ready_i,
    input  logic                    mem_rsp_valid_i,
    input  llc_pkg::mem_rsp_t       mem_rsp_i,
    output logic                    mem_req_valid_o,
    output llc_pkg::mem_req_t       mem_req_o,
    output logic                    mem_rsp_ready_o,
    output logic                    done_o,
    output logic [WAY_BITS-1:0]     upd_way_o,
    output llc_pkg::llc_state_e     upd_state_o,
    output llc_pkg::line_t          upd_line_o,
    output logic                    fill_o,
    output llc_pkg::line_t          rsp_line_o
);
    import llc_pkg::*;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WRITEBACK = 2'd1,
        FILL_REQ  = 2'd2,
        FILL_WAIT = 2'd3
    } proc_state_e;

    proc_state_e state_q;
    proc_state_e state_d;
    logic        is_write;
    line_addr_t  victim_addr;

    assign is_write    = (req_i.op == OP_WRITE);
    // victim sits in the same set as the request
    assign victim_addr = {victim_tag_i, req_i.addr[SET_BITS-1:0]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // memory request payload, stable while valid is held
    always_comb begin
        mem_req_o.write = (state_q == WRITEBACK);
        mem_req_o.addr  = (state_q == WRITEBACK) ? victim_addr : req_i.addr;
        mem_req_o.line  = (state_q == WRITEBACK) ? victim_line_i : '0;
    end

    // result of the request
    always_comb begin
        upd_way_o   = hit_i ? hit_way_i : victim_way_i;
        upd_state_o = is_write ? DIRTY : VALID;
        if (is_write) begin
            upd_line_o = req_i.line;
        end else if (hit_i) begin
            upd_line_o = hit_line_i;
        end else begin
            upd_line_o = mem_rsp_i.line;
        end
    end

    assign rsp_line_o = upd_line_o;

    always_comb begin
        state_d         = state_q;
        done_o          = 1'b0;
        fill_o          = 1'b0;
        mem_req_valid_o = 1'b0;
        mem_rsp_ready_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    if (hit_i) begin
                        done_o = 1'b1;
                    end else if (victim_dirty_i) begin
                        state_d = WRITEBACK;
                    end else if (!is_write) begin
                        state_d = FILL_REQ;
                    end else begin
                        // write miss on a clean victim installs at once
                        done_o = 1'b1;
                        fill_o = 1'b1;
                    end
                end
            end
            WRITEBACK: begin
                mem_req_valid_o = 1'b1;
                if (mem_req_ready_i) begin
                    if (is_write) begin
                        state_d = IDLE;
                        done_o  = 1'b1;
                        fill_o  = 1'b1;
                    end else begin
                        state_d = FILL_REQ;
                    end
                end
            end
            FILL_REQ: begin
                mem_req_valid_o = 1'b1;
                if (mem_req_ready_i) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                mem_rsp_ready_o = 1'b1;
                if (mem_rsp_valid_i) begin
                    state_d = IDLE;
                    done_o  = 1'b1;
                    fill_o  = 1'b1;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

// ==== src/llc_lookup_way.sv ====
////////////////////////////////////////////////////////////////////////////
// way lookup and victim selection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_lookup_way #(
    parameter int SET_BITS = 4,
    parameter int WAY_BITS = 2,
    localparam int TAG_BITS = llc_pkg::LINE_ADDR_BITS - SET_BITS,
    localparam int WAYS = 1 << WAY_BITS
) (
    input  logic [TAG_BITS-1:0]                 tag_i,
    input  logic [WAYS-1:0][TAG_BITS-1:0]       tags_i,
    input  llc_pkg::llc_state_e [WAYS-1:0]      states_i,
    input  llc_pkg::line_t [WAYS-1:0]           lines_i,
    input  logic [WAY_BITS-1:0]                 evict_way_i,
    output logic                                hit_o,
    output logic [WAY_BITS-1:0]                 hit_way_o,
    output logic [WAY_BITS-1:0]                 victim_way_o,
    output logic                                victim_dirty_o,
    output logic [TAG_BITS-1:0]                 victim_tag_o,
    output llc_pkg::line_t                      victim_line_o,
    output llc_pkg::line_t                      hit_line_o
);
    import llc_pkg::*;

    always_comb begin
        hit_o        = 1'b0;
        hit_way_o    = '0;
        victim_way_o = evict_way_i;
        // descending scan so the lowest matching way wins
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (states_i[w] != INVALID && tags_i[w] == tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = WAY_BITS'(w);
            end
            if (states_i[w] == INVALID) begin
                victim_way_o = WAY_BITS'(w);
            end
        end
    end

    // victim contents for a possible writeback
    assign victim_dirty_o = (states_i[victim_way_o] == DIRTY);
    assign victim_tag_o   = tags_i[victim_way_o];
    assign victim_line_o  = lines_i[victim_way_o];
    assign hit_line_o     = lines_i[hit_way_o];

endmodule

// ==== src/llc_localmem.sv ====
////////////////////////////////////////////////////////////////////////////
// cache arrays and eviction pointers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_localmem #(
    parameter int SET_BITS = 4,
    parameter int WAY_BITS = 2,
    localparam int TAG_BITS = llc_pkg::LINE_ADDR_BITS - SET_BITS,
    localparam int WAYS = 1 << WAY_BITS
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rd_en_i,
    input  logic [SET_BITS-1:0]                 rd_set_i,
    input  logic                                wr_en_i,
    input  logic [SET_BITS-1:0]                 wr_set_i,
    input  logic [WAY_BITS-1:0]                 wr_way_i,
    input  logic [TAG_BITS-1:0]                 wr_tag_i,
    input  llc_pkg::llc_state_e                 wr_state_i,
    input  llc_pkg::line_t                      wr_line_i,
    input  logic                                incr_evict_i,
    output logic [WAYS-1:0][TAG_BITS-1:0]       rd_tags_o,
    output llc_pkg::llc_state_e [WAYS-1:0]      rd_states_o,
    output llc_pkg::line_t [WAYS-1:0]           rd_lines_o,
    output logic [WAY_BITS-1:0]                 rd_evict_way_o
);
    import llc_pkg::*;

    localparam int SETS = 1 << SET_BITS;

    logic [WAYS-1:0][TAG_BITS-1:0] tag_mem [SETS];
    line_t [WAYS-1:0]              line_mem [SETS];
    llc_state_e [WAYS-1:0]         state_mem [SETS];
    logic [WAY_BITS-1:0]           evict_mem [SETS];

    // states and round-robin pointers start cleared
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    state_mem[s][w] <= INVALID;
                end
                evict_mem[s] <= '0;
            end
        end else begin
            if (wr_en_i) begin
                state_mem[wr_set_i][wr_way_i] <= wr_state_i;
            end
            // wraps at the way count
            if (incr_evict_i) begin
                evict_mem[wr_set_i] <= evict_mem[wr_set_i] + 1'b1;
            end
        end
    end

    // tag and data arrays, registered read of a whole set
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_set_i][wr_way_i]  <= wr_tag_i;
            line_mem[wr_set_i][wr_way_i] <= wr_line_i;
        end
        if (rd_en_i) begin
            rd_tags_o      <= tag_mem[rd_set_i];
            rd_states_o    <= state_mem[rd_set_i];
            rd_lines_o     <= line_mem[rd_set_i];
            rd_evict_way_o <= evict_mem[rd_set_i];
        end
    end

endmodule

// ==== src/llc_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// last-level cache shared types
////////////////////////////////////////////////////////////////////////////

package llc_pkg;

    // address geometry
    localparam int ADDR_BITS      = 32;
    localparam int OFFSET_BITS    = 4;
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    // line geometry, 16 bytes per line
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] line_t;

    // per-way line state
    typedef enum logic [1:0] {
        INVALID = 2'd0,
        VALID   = 2'd1,
        DIRTY   = 2'd2
    } llc_state_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } llc_op_e;

    // requester side
    typedef struct packed {
        llc_op_e    op;
        line_addr_t addr;
        line_t      line;
    } llc_req_t;

    typedef struct packed {
        line_t line;
        logic  hit;
    } llc_rsp_t;

    // main memory side
    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_t      line;
    } mem_req_t;

    typedef struct packed {
        line_t line;
    } mem_rsp_t;

    // core stages, one request in flight
    typedef enum logic [1:0] {
        READ_MEM = 2'd0,
        LOOKUP   = 2'd1,
        PROCESS  = 2'd2,
        UPDATE   = 2'd3
    } stage_e;

endpackage
